// ==== Bender.yml ====
package:
  name: usb_bridge

sources:
  - files:
      - rtl/usb_bridge_pkg.sv
      - rtl/usb_rx_dispatch.sv
      - rtl/byte_fifo.sv
      - rtl/uart_tx_serializer.sv
      - rtl/usb_bridge_top.sv
  - target: test
    include_dirs:
      - testbench
    files:
      - testbench/tb_usb_bridge.sv

// ==== filelist.f ====
+incdir+testbench
rtl/usb_bridge_pkg.sv
rtl/usb_rx_dispatch.sv
rtl/byte_fifo.sv
rtl/uart_tx_serializer.sv
rtl/usb_bridge_top.sv
testbench/tb_usb_bridge.sv

// ==== rtl/byte_fifo.sv ====
`timescale 1ns/100ps
`default_nettype none

module byte_fifo
  import usb_bridge_pkg::*;
#(
  parameter int DEPTH = FIFO_DEPTH  // power of two
) (
  input  wire             PHY_CLKOUT,
  input  wire             rst_n_i,
  input  wire usb_byte_t  push_data_i,
  input  wire             push_valid_i,
  input  wire             pop_ready_i,
  output logic            push_ready_o,
  output usb_byte_t       pop_data_o,
  output logic            pop_valid_o
);

  // one extra msb on each pointer tells full from empty
  typedef logic [$clog2(DEPTH):0] ptr_t;

  usb_byte_t mem [DEPTH];
  ptr_t      wr_ptr_q;
  ptr_t      rd_ptr_q;
  logic      empty;
  logic      full;
  logic      do_push;
  logic      do_pop;

  // ==================================================
  // status and handshakes
  // ==================================================
  assign empty = (wr_ptr_q == rd_ptr_q);
  assign full  = (wr_ptr_q[$clog2(DEPTH)] != rd_ptr_q[$clog2(DEPTH)]) &&
                 (wr_ptr_q[$clog2(DEPTH)-1:0] == rd_ptr_q[$clog2(DEPTH)-1:0]);

  assign push_ready_o = !full || pop_ready_i;  // a pop frees the slot this cycle
  assign pop_valid_o  = !empty;
  assign pop_data_o   = mem[rd_ptr_q[$clog2(DEPTH)-1:0]];  // show-ahead

  assign do_push = push_valid_i && push_ready_o;
  assign do_pop  = pop_valid_o && pop_ready_i;

  // ==================================================
  // storage and pointers
  // ==================================================
  always_ff @(posedge PHY_CLKOUT) begin
    if (do_push) begin
      mem[wr_ptr_q[$clog2(DEPTH)-1:0]] <= push_data_i;
    end
  end

  always_ff @(posedge PHY_CLKOUT or negedge rst_n_i) begin
    if (!rst_n_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
    end else begin
      if (do_push) begin
        wr_ptr_q <= wr_ptr_q + 1'b1;
      end
      if (do_pop) begin
        rd_ptr_q <= rd_ptr_q + 1'b1;
      end
    end
  end

endmodule

`default_nettype wire

// ==== rtl/uart_tx_serializer.sv ====
`timescale 1ns/100ps
`default_nettype none

module uart_tx_serializer
  import usb_bridge_pkg::*;
(
  input  wire             PHY_CLKOUT,
  input  wire             rst_n_i,
  input  wire usb_byte_t  pop_data_i,
  input  wire             pop_valid_i,
  output logic            pop_ready_o,
  output logic            uart_txd_o
);

  logic                        busy_q;
  logic [UART_CNT_W-1:0]       cnt_q;      // cycles within the current bit
  logic [3:0]                  bit_idx_q;  // 0 start, 1..8 data, 9 stop
  logic [$bits(usb_byte_t):0]  shift_q;    // data bits then stop bit
  logic                        txd_q;
  logic                        take;
  logic                        bit_end;
  logic                        last_bit;

  assign pop_ready_o = !busy_q;
  assign take        = pop_valid_i && !busy_q;
  assign bit_end     = (cnt_q == UART_CNT_W'(UART_CLKS_PER_BIT - 1));
  assign last_bit    = (bit_idx_q == 4'(UART_FRAME_BITS - 1));
  assign uart_txd_o  = txd_q;

  // ==================================================
  // frame sequencing
  // ==================================================
  always_ff @(posedge PHY_CLKOUT or negedge rst_n_i) begin
    if (!rst_n_i) begin
      busy_q    <= 1'b0;
      cnt_q     <= '0;
      bit_idx_q <= 4'd0;
      txd_q     <= 1'b1;  // line idles high
    end else if (take) begin
      busy_q    <= 1'b1;
      cnt_q     <= '0;
      bit_idx_q <= 4'd0;
      txd_q     <= 1'b0;  // start bit
    end else if (busy_q) begin
      if (bit_end) begin
        cnt_q <= '0;
        if (last_bit) begin
          busy_q <= 1'b0;  // stop bit done, ready for next byte
          txd_q  <= 1'b1;
        end else begin
          bit_idx_q <= bit_idx_q + 4'd1;
          txd_q     <= shift_q[0];  // lsb first
        end
      end else begin
        cnt_q <= cnt_q + 1'b1;
      end
    end
  end

  // ==================================================
  // shift register
  // ==================================================
  always_ff @(posedge PHY_CLKOUT) begin
    if (take) begin
      shift_q <= {1'b1, pop_data_i};  // stop bit rides behind the data
    end else if (busy_q && bit_end && !last_bit) begin
      shift_q <= shift_q >> 1;
    end
  end

endmodule

`default_nettype wire

// ==== rtl/usb_bridge_pkg.sv ====
`default_nettype none

package usb_bridge_pkg;

  // ==================================================
  // data types
  // ==================================================
  localparam int NUM_GPIO = 10;  // parallel output width

  typedef logic [3:0]          endpt_t;     // usb endpoint number
  typedef logic [7:0]          usb_byte_t;  // one payload byte
  typedef logic [NUM_GPIO-1:0] gpio_t;      // parallel output word

  // ==================================================
  // endpoint map
  // ==================================================
  localparam endpt_t ENDPT_UART_DATA = 4'h5;  // bytes go out on the uart line
  localparam endpt_t ENDPT_PARALLEL  = 4'h8;  // packet sets the gpio word

  // ==================================================
  // buffering and uart timing
  // ==================================================
  localparam int FIFO_DEPTH = 8;  // must be a power of two

  // fixed baud, one bit every UART_CLKS_PER_BIT cycles of PHY_CLKOUT
  localparam int UART_CLKS_PER_BIT = 8;  // small for simulation
  localparam int UART_CNT_W        = $clog2(UART_CLKS_PER_BIT);
  localparam int UART_FRAME_BITS   = 10;  // start + 8 data + stop

endpackage

`default_nettype wire

// ==== rtl/usb_bridge_top.sv ====
`timescale 1ns/100ps
`default_nettype none

module usb_bridge_top
  import usb_bridge_pkg::*;
(
  input  wire             PHY_CLKOUT,
  input  wire             rst_n_i,
  input  wire endpt_t     endpt_i,      // stable while rxact_i high
  input  wire usb_byte_t  rxdat_i,
  input  wire             rxval_i,
  input  wire             rxact_i,
  input  wire             rxpktval_i,   // good packet strobe
  output wire             rxrdy_o,
  output wire             uart_txd_o,
  output wire gpio_t      parallel_gpio_o
);

  wire usb_byte_t push_data;
  wire            push_valid;
  wire            push_ready;
  wire usb_byte_t pop_data;
  wire            pop_valid;
  wire            pop_ready;

  // ==================================================
  // endpoint dispatcher
  // ==================================================
  usb_rx_dispatch u_dispatch (
    .PHY_CLKOUT      (PHY_CLKOUT),
    .rst_n_i         (rst_n_i),
    .endpt_i         (endpt_i),
    .rxdat_i         (rxdat_i),
    .rxval_i         (rxval_i),
    .rxact_i         (rxact_i),
    .rxpktval_i      (rxpktval_i),
    .push_ready_i    (push_ready),
    .rxrdy_o         (rxrdy_o),
    .push_data_o     (push_data),
    .push_valid_o    (push_valid),
    .parallel_gpio_o (parallel_gpio_o)
  );

  // ==================================================
  // byte buffer
  // ==================================================
  byte_fifo #(
    .DEPTH (FIFO_DEPTH)
  ) u_fifo (
    .PHY_CLKOUT   (PHY_CLKOUT),
    .rst_n_i      (rst_n_i),
    .push_data_i  (push_data),
    .push_valid_i (push_valid),
    .pop_ready_i  (pop_ready),
    .push_ready_o (push_ready),
    .pop_data_o   (pop_data),
    .pop_valid_o  (pop_valid)
  );

  // ==================================================
  // uart transmitter
  // ==================================================
  uart_tx_serializer u_uart_tx (
    .PHY_CLKOUT  (PHY_CLKOUT),
    .rst_n_i     (rst_n_i),
    .pop_data_i  (pop_data),
    .pop_valid_i (pop_valid),
    .pop_ready_o (pop_ready),
    .uart_txd_o  (uart_txd_o)
  );

endmodule

`default_nettype wire

// ==== rtl/usb_rx_dispatch.sv ====
`timescale 1ns/100ps
`default_nettype none

module usb_rx_dispatch
  import usb_bridge_pkg::*;
(
  input  wire             PHY_CLKOUT,
  input  wire             rst_n_i,
  input  wire endpt_t     endpt_i,
  input  wire usb_byte_t  rxdat_i,
  input  wire             rxval_i,
  input  wire             rxact_i,
  input  wire             rxpktval_i,
  input  wire             push_ready_i,
  output logic            rxrdy_o,
  output usb_byte_t       push_data_o,
  output logic            push_valid_o,
  output gpio_t           parallel_gpio_o
);

  logic                ep_uart;
  logic                ep_par;
  logic                uart_take;
  logic                par_take;
  logic [1:0]          byte_cnt_q;  // bytes seen in this parallel packet, saturates at 2
  logic [1:0]          stage_vld_q; // bit 0 low staging valid, bit 1 high staging valid
  usb_byte_t           stage_lo_q;
  logic [NUM_GPIO-9:0] stage_hi_q;

  // ==================================================
  // endpoint decode and ready
  // ==================================================
  assign ep_uart = (endpt_i == ENDPT_UART_DATA);
  assign ep_par  = (endpt_i == ENDPT_PARALLEL);

  assign rxrdy_o = ep_uart ? push_ready_i : ep_par;  // other endpoints refused

  assign uart_take = rxact_i && rxval_i && ep_uart && push_ready_i;
  assign par_take  = rxact_i && rxval_i && ep_par;

  // ==================================================
  // uart endpoint, one register stage into the fifo
  // ==================================================
  // the stage only moves when the fifo can take, so a held byte is never lost
  always_ff @(posedge PHY_CLKOUT or negedge rst_n_i) begin
    if (!rst_n_i) begin
      push_valid_o <= 1'b0;
    end else if (push_ready_i) begin
      push_valid_o <= uart_take;
    end
  end

  always_ff @(posedge PHY_CLKOUT) begin
    if (uart_take) begin
      push_data_o <= rxdat_i;
    end
  end

  // ==================================================
  // parallel endpoint
  // ==================================================
  always_ff @(posedge PHY_CLKOUT) begin
    if (par_take && byte_cnt_q == 2'd0) begin
      stage_lo_q <= rxdat_i;
    end
    if (par_take && byte_cnt_q == 2'd1) begin
      stage_hi_q <= rxdat_i[NUM_GPIO-9:0];  // two lsbs of byte 1
    end
  end

  always_ff @(posedge PHY_CLKOUT or negedge rst_n_i) begin
    if (!rst_n_i) begin
      byte_cnt_q      <= 2'd0;
      stage_vld_q     <= 2'b00;
      parallel_gpio_o <= '0;
    end else begin
      if (!rxact_i) begin
        byte_cnt_q <= 2'd0;
      end else if (par_take && byte_cnt_q != 2'd2) begin
        byte_cnt_q <= byte_cnt_q + 2'd1;
      end

      if (par_take && byte_cnt_q == 2'd0) begin
        stage_vld_q <= 2'b01;  // new packet, high half not yet seen
      end else if (par_take && byte_cnt_q == 2'd1) begin
        stage_vld_q[1] <= 1'b1;
      end else if ((rxact_i && byte_cnt_q == 2'd0) || rxpktval_i) begin
        stage_vld_q <= 2'b00;  // packet start or staging consumed
      end

      // only a good packet commits, one-byte packets keep the high bits
      if (rxpktval_i && ep_par) begin
        if (stage_vld_q[0]) begin
          parallel_gpio_o[7:0] <= stage_lo_q;
        end
        if (stage_vld_q[1]) begin
          parallel_gpio_o[NUM_GPIO-1:8] <= stage_hi_q;
        end
      end
    end
  end

endmodule

`default_nettype wire

// ==== testbench/tb_tasks.svh ====
`ifndef TB_TASKS_SVH
`define TB_TASKS_SVH

// ==================================================
// compare tasks
// ==================================================
task automatic check_gpio(input gpio_t got, input gpio_t exp, input string what);
  if (got !== exp) begin
    errors++;
    $display("ERROR @%0t: %s, gpio 0x%03h expected 0x%03h", $time, what, got, exp);
  end
endtask

task automatic check_byte(input usb_byte_t got, input usb_byte_t exp, input string what);
  if (got !== exp) begin
    errors++;
    $display("ERROR @%0t: %s, byte 0x%02h expected 0x%02h", $time, what, got, exp);
  end
endtask

task automatic check_bit(input logic got, input logic exp, input string what);
  if (got !== exp) begin
    errors++;
    $display("ERROR @%0t: %s, got %b expected %b", $time, what, got, exp);
  end
endtask

// ==================================================
// host side driver
// ==================================================
task automatic send_packet(input endpt_t ep, input usb_byte_t bytes[$], input logic good);
  int waits;
  @(negedge PHY_CLKOUT);
  endpt_i = ep;  // idle first cycle, rxrdy_o settles
  rxact_i = 1'b1;
  foreach (bytes[i]) begin
    @(negedge PHY_CLKOUT);
    rxdat_i = bytes[i];
    rxval_i = 1'b1;
    waits   = 0;
    while (!rxrdy_o && waits < RDY_TIMEOUT) begin
      saw_stall = 1'b1;  // host holds the byte
      @(negedge PHY_CLKOUT);
      waits++;
    end
    if (!rxrdy_o) begin
      timeouts++;
      $display("timeout: rxrdy_o stayed low for byte %0d on endpoint %0d", i, ep);
    end
  end
  @(negedge PHY_CLKOUT);
  rxval_i    = 1'b0;
  rxact_i    = 1'b0;
  rxpktval_i = good;
  @(negedge PHY_CLKOUT);
  rxpktval_i = 1'b0;
endtask

// ==================================================
// uart line decoder
// ==================================================
task automatic recv_uart_byte(output usb_byte_t data, output logic ok);
  int waits;
  waits = 0;
  ok    = 1'b0;
  data  = '0;
  while (uart_txd_o !== 1'b0 && waits < START_TIMEOUT) begin
    @(negedge PHY_CLKOUT);
    waits++;
  end
  if (uart_txd_o !== 1'b0) begin
    timeouts++;
    $display("timeout: no start bit appeared on uart_txd_o");
    return;
  end
  repeat (UART_CLKS_PER_BIT / 2) @(negedge PHY_CLKOUT);  // middle of start bit
  check_bit(uart_txd_o, 1'b0, "start bit");
  for (int b = 0; b < 8; b++) begin
    repeat (UART_CLKS_PER_BIT) @(negedge PHY_CLKOUT);
    data[b] = uart_txd_o;  // lsb first
  end
  repeat (UART_CLKS_PER_BIT) @(negedge PHY_CLKOUT);
  check_bit(uart_txd_o, 1'b1, "stop bit");
  ok = 1'b1;
endtask

`endif

// ==== testbench/tb_usb_bridge.sv ====
`timescale 1ns/100ps
`default_nettype none

module tb_usb_bridge
  import usb_bridge_pkg::*;
();

  localparam int     RDY_TIMEOUT    = 200;  // longer than one 80-cycle frame
  localparam int     START_TIMEOUT  = 200;
  localparam int     UNKNOWN_WINDOW = 200;
  localparam int     UART_BYTES     = 5;
  localparam int     BP_BYTES       = 12;
  localparam endpt_t ENDPT_UNKNOWN  = 4'h3;

  logic      PHY_CLKOUT;
  logic      rst_n_i;
  endpt_t    endpt_i;
  usb_byte_t rxdat_i;
  logic      rxval_i;
  logic      rxact_i;
  logic      rxpktval_i;
  wire       rxrdy_o;
  wire       uart_txd_o;
  wire gpio_t parallel_gpio_o;

  int    errors;
  int    timeouts;
  logic  saw_stall;  // rxrdy_o seen low during a byte
  gpio_t exp_gpio;   // model of the parallel output

  usb_bridge_top dut0 (
    .PHY_CLKOUT      (PHY_CLKOUT),
    .rst_n_i         (rst_n_i),
    .endpt_i         (endpt_i),
    .rxdat_i         (rxdat_i),
    .rxval_i         (rxval_i),
    .rxact_i         (rxact_i),
    .rxpktval_i      (rxpktval_i),
    .rxrdy_o         (rxrdy_o),
    .uart_txd_o      (uart_txd_o),
    .parallel_gpio_o (parallel_gpio_o)
  );

  `include "tb_tasks.svh"

  initial begin
    PHY_CLKOUT = 1'b0;
    forever #5 PHY_CLKOUT = ~PHY_CLKOUT;
  end

  // ==================================================
  // tests
  // ==================================================
  task automatic test_reset_state();
    rst_n_i = 1'b0;
    repeat (10) @(negedge PHY_CLKOUT);
    rst_n_i = 1'b1;
    @(negedge PHY_CLKOUT);
    check_bit(uart_txd_o, 1'b1, "uart_txd_o after reset");
    check_gpio(parallel_gpio_o, '0, "parallel_gpio_o after reset");
  endtask

  task automatic test_parallel_two_byte();
    usb_byte_t q[$];
    q.push_back(usb_byte_t'($urandom));
    q.push_back(usb_byte_t'($urandom));
    send_packet(ENDPT_PARALLEL, q, 1'b1);
    exp_gpio = {q[1][1:0], q[0]};  // byte 1 supplies the top two bits
    check_gpio(parallel_gpio_o, exp_gpio, "two-byte parallel packet");
  endtask

  task automatic test_parallel_bad_and_short();
    usb_byte_t q[$];
    q.push_back(~exp_gpio[7:0]);
    q.push_back(usb_byte_t'(~exp_gpio[9:8]));
    send_packet(ENDPT_PARALLEL, q, 1'b0);
    check_gpio(parallel_gpio_o, exp_gpio, "packet without rxpktval_i");
    q.delete();
    q.push_back(usb_byte_t'($urandom));
    send_packet(ENDPT_PARALLEL, q, 1'b1);
    exp_gpio[7:0] = q[0];  // high bits keep their value
    check_gpio(parallel_gpio_o, exp_gpio, "one-byte parallel packet");
  endtask

  task automatic run_uart_stream(input int n, input string what);
    usb_byte_t sent[$];
    usb_byte_t got;
    logic      ok;
    repeat (n) sent.push_back(usb_byte_t'($urandom));
    fork
      send_packet(ENDPT_UART_DATA, sent, 1'b1);
      for (int i = 0; i < n; i++) begin
        recv_uart_byte(got, ok);
        if (ok) begin
          check_byte(got, sent[i], what);
        end
      end
    join
  endtask

  task automatic test_back_pressure();
    saw_stall = 1'b0;
    run_uart_stream(BP_BYTES, "back-pressure byte");
    check_bit(saw_stall, 1'b1, "rxrdy_o low while FIFO full");
  endtask

  task automatic test_unknown_endpoint();
    logic rdy_seen;
    logic start_seen;
    rdy_seen   = 1'b0;
    start_seen = 1'b0;
    @(negedge PHY_CLKOUT);
    endpt_i = ENDPT_UNKNOWN;
    rxact_i = 1'b1;
    @(negedge PHY_CLKOUT);
    rxdat_i = 8'hc3;
    rxval_i = 1'b1;
    repeat (UNKNOWN_WINDOW) begin
      @(negedge PHY_CLKOUT);
      rdy_seen   = rdy_seen | rxrdy_o;
      start_seen = start_seen | !uart_txd_o;
    end
    rxval_i    = 1'b0;
    rxact_i    = 1'b0;
    rxpktval_i = 1'b1;
    @(negedge PHY_CLKOUT);
    rxpktval_i = 1'b0;
    check_bit(rdy_seen, 1'b0, "rxrdy_o on unknown endpoint");
    check_bit(start_seen, 1'b0, "start bit after unknown endpoint");
    check_gpio(parallel_gpio_o, exp_gpio, "unknown endpoint");
  endtask

  // ==================================================
  // sequence and report
  // ==================================================
  initial begin
    void'($urandom(47));
    errors     = 0;
    timeouts   = 0;
    saw_stall  = 1'b0;
    exp_gpio   = '0;
    rst_n_i    = 1'b0;
    endpt_i    = '0;
    rxdat_i    = '0;
    rxval_i    = 1'b0;
    rxact_i    = 1'b0;
    rxpktval_i = 1'b0;
    test_reset_state();
    test_parallel_two_byte();
    test_parallel_bad_and_short();
    run_uart_stream(UART_BYTES, "uart byte");
    test_back_pressure();
    test_unknown_endpoint();
    $display("run complete: %0d errors, %0d timeouts", errors, timeouts);
    if (errors == 0 && timeouts == 0) begin
      $display(">>> PASS");
    end else begin
      $display(">>> FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire
